// ==== include/mulPipe_settings.svh ====
`ifndef MULPIPE_SETTINGS_SVH
`define MULPIPE_SETTINGS_SVH

// operand widths, X must not be wider than Y
`define MUL_WIDTH_X 8
`define MUL_WIDTH_Y 8
`define MUL_WIDTH_P (`MUL_WIDTH_X + `MUL_WIDTH_Y) // full product

// one row per multiplier bit plus two rows of correction constants
`define MUL_ROWS (`MUL_WIDTH_X + 2)

`define MUL_LATENCY 3 // ppGen, csa, cpa

`endif

// ==== mulPipe.f ====
+incdir+include
source/mulPipePkg.sv
source/ppGenStage.sv
source/csaStage.sv
source/cpaStage.sv
source/mulPipe.sv
tests/mulPipe_assert.sv
tests/mulPipe_tb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# compile and run the mulPipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f mulPipe.f --top-module mulPipe_tb \
	-Mdir obj_dir -o simMulPipe > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# an aborted run counts as a failure
./obj_dir/simMulPipe > sim.log 2>&1 || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } || { echo "simulation passed"; exit 0; }

// ==== source/cpaStage.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

module cpaStage (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 csValid,  // strobe from stage 2
	input  mulPipePkg::csVec_t   csVec,
	output mulPipePkg::product_t product,  // registered final product
	output logic                 outValid
);

	localparam int prefixLevels = $clog2(`MUL_WIDTH_P); // Sklansky depth

	// generate and propagate, level 0 is the raw input
	logic [prefixLevels:0][`MUL_WIDTH_P-1:0] gLvl;
	logic [prefixLevels:0][`MUL_WIDTH_P-1:0] pLvl;
	mulPipePkg::product_t halfSum; // a xor b
	mulPipePkg::product_t sumNext;

	assign gLvl[0] = csVec.sum & csVec.carry;
	assign pLvl[0] = csVec.sum | csVec.carry; // or-propagate is enough for carries
	assign halfSum = ~gLvl[0] & pLvl[0];

	// Sklansky tree, each level doubles the span of every group
	for (genvar l = 1; l <= prefixLevels; l++) begin : level
		for (genvar k = 0; k < 2**(prefixLevels-l); k++) begin : group
			localparam int base  = k * 2**l;
			localparam int pivot = base + 2**(l-1) - 1; // top of lower half
			for (genvar i = 0; i < 2**(l-1); i++) begin : node
				localparam int lo = base + i;
				localparam int hi = base + 2**(l-1) + i;
				// lower half passes through
				if (lo < `MUL_WIDTH_P) begin : white
					assign gLvl[l][lo] = gLvl[l-1][lo];
					assign pLvl[l][lo] = pLvl[l-1][lo];
				end
				// upper half merges with the pivot's group
				if (hi < `MUL_WIDTH_P) begin : black
					assign gLvl[l][hi] = gLvl[l-1][hi] | (pLvl[l-1][hi] & gLvl[l-1][pivot]);
					assign pLvl[l][hi] = pLvl[l-1][hi] & pLvl[l-1][pivot];
				end
			end
		end
	end

	// carry into bit i is the prefix generate of bit i-1
	assign sumNext = halfSum ^ {gLvl[prefixLevels][`MUL_WIDTH_P-2:0], 1'b0};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			product  <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= csValid;
			if (csValid) begin
				product <= sumNext; // carry out of msb is dropped
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/csaStage.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

module csaStage (
	input  logic                clk,
	input  logic                rstN,
	input  logic                ppValid, // strobe from stage 1
	input  mulPipePkg::ppRows_t ppRows,
	output mulPipePkg::csVec_t  csVec,   // registered sum and carry
	output logic                csValid
);

	// carries between neighbouring column compressors
	logic [`MUL_WIDTH_P-1:0][`MUL_ROWS-4:0] midCarry;
	mulPipePkg::product_t sumNext;   // one sum bit per column
	mulPipePkg::product_t carryRaw;  // column carries, not yet shifted
	mulPipePkg::csVec_t   csNext;

	assign midCarry[0] = '0; // nothing below bit 0

	// one (ROWS,2) tree compressor per bit weight
	for (genvar i = 0; i < `MUL_WIDTH_P; i++) begin : column
		// bit queue, inputs first, FA sums and incoming carries appended
		logic [3*`MUL_ROWS-6:0] fTree;
		logic [`MUL_ROWS-3:0]   cOut; // FA carries, all go one column up

		// regroup, bit i of every row lands in this column
		for (genvar k = 0; k < `MUL_ROWS; k++) begin : gather
			assign fTree[k] = ppRows.row[k][i];
		end

		for (genvar j = 0; j < `MUL_ROWS-2; j++) begin : fa
			// full adder eats three queue entries
			assign fTree[`MUL_ROWS+2*j] = fTree[3*j] ^ fTree[3*j+1] ^ fTree[3*j+2];
			assign cOut[j] = (fTree[3*j] & fTree[3*j+1])
				| (fTree[3*j+2] & (fTree[3*j] ^ fTree[3*j+1]));
			// carry from the column below joins the queue behind the sum
			if (j < `MUL_ROWS-3) begin : takeCarry
				assign fTree[`MUL_ROWS+2*j+1] = midCarry[i][j];
			end
		end

		// pass intermediate carries upward, dropped past the top column
		if (i < `MUL_WIDTH_P-1) begin : fwdCarry
			assign midCarry[i+1] = cOut[`MUL_ROWS-4:0];
		end

		assign sumNext[i]  = fTree[3*`MUL_ROWS-6]; // last FA sum
		assign carryRaw[i] = cOut[`MUL_ROWS-3];    // last FA carry
	end

	// carry vector weighted one place up, top carry falls off mod 2^P
	assign csNext.sum   = sumNext;
	assign csNext.carry = {carryRaw[`MUL_WIDTH_P-2:0], 1'b0};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			csVec   <= '0;
			csValid <= 1'b0;
		end else begin
			csValid <= ppValid;
			if (ppValid) begin
				csVec <= csNext; // hold otherwise
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/mulPipe.sv ====
`default_nettype none

module mulPipe (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  inValid,  // one pair per cycle at most
	input  mulPipePkg::operandX_t x,
	input  mulPipePkg::operandY_t y,
	output mulPipePkg::product_t  product,  // x*y, three cycles later
	output logic                  outValid
);

	mulPipePkg::ppRows_t ppRows;  // stage 1 to 2
	logic                ppValid;
	mulPipePkg::csVec_t  csVec;   // stage 2 to 3
	logic                csValid;

	// partial products
	ppGenStage ppGen (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.x       (x),
		.y       (y),
		.ppRows  (ppRows),
		.ppValid (ppValid)
	);

	// carry-save reduction
	csaStage csa (
		.clk     (clk),
		.rstN    (rstN),
		.ppValid (ppValid),
		.ppRows  (ppRows),
		.csVec   (csVec),
		.csValid (csValid)
	);

	// final prefix adder
	cpaStage cpa (
		.clk      (clk),
		.rstN     (rstN),
		.csValid  (csValid),
		.csVec    (csVec),
		.product  (product),
		.outValid (outValid)
	);

endmodule

`default_nettype wire

// ==== source/mulPipePkg.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

package mulPipePkg;

	typedef logic [`MUL_WIDTH_X-1:0] operandX_t; // multiplier, two's complement
	typedef logic [`MUL_WIDTH_Y-1:0] operandY_t; // multiplicand, two's complement
	typedef logic [`MUL_WIDTH_P-1:0] product_t;  // signed product, also row width

	// partial-product rows out of stage 1
	typedef struct packed {
		product_t [`MUL_ROWS-1:0] row; // each row already at its bit weight
	} ppRows_t;

	// redundant form out of stage 2
	typedef struct packed {
		product_t sum;   // column sums
		product_t carry; // column carries, already moved up one place
	} csVec_t;

endpackage

`default_nettype wire

// ==== source/ppGenStage.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

module ppGenStage (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  inValid, // operand strobe
	input  mulPipePkg::operandX_t x,       // multiplier
	input  mulPipePkg::operandY_t y,       // multiplicand
	output mulPipePkg::ppRows_t   ppRows,  // registered rows
	output logic                  ppValid
);

	mulPipePkg::ppRows_t ppNext; // rows before the register

	// Baugh-Wooley rows, all summed unsigned give x*y mod 2^P
	always_comb begin
		ppNext = '0;

		// plain rows, the one sign bit term of each is inverted
		for (int i = 0; i < `MUL_WIDTH_X-1; i++) begin
			for (int k = 0; k < `MUL_WIDTH_Y-1; k++) begin
				ppNext.row[i][i+k] = x[i] & y[k]; // magnitude x magnitude
			end
			ppNext.row[i][i+`MUL_WIDTH_Y-1] = ~x[i] & y[`MUL_WIDTH_Y-1];
		end

		// sign row of x, again one sign bit per term
		for (int k = 0; k < `MUL_WIDTH_Y-1; k++) begin
			ppNext.row[`MUL_WIDTH_X-1][`MUL_WIDTH_X-1+k] = x[`MUL_WIDTH_X-1] & ~y[k];
		end
		// two sign bits, so the term stays positive
		ppNext.row[`MUL_WIDTH_X-1][`MUL_WIDTH_P-2] = x[`MUL_WIDTH_X-1] & y[`MUL_WIDTH_Y-1];

		// correction constants of x's sign
		ppNext.row[`MUL_WIDTH_X][`MUL_WIDTH_P-2]   = ~x[`MUL_WIDTH_X-1];
		ppNext.row[`MUL_WIDTH_X][`MUL_WIDTH_X-1]   = x[`MUL_WIDTH_X-1];

		// correction constants of y's sign, plus the -2^(P-1) wrap bit
		ppNext.row[`MUL_WIDTH_X+1][`MUL_WIDTH_P-1] = 1'b1;
		ppNext.row[`MUL_WIDTH_X+1][`MUL_WIDTH_P-2] = ~y[`MUL_WIDTH_Y-1];
		ppNext.row[`MUL_WIDTH_X+1][`MUL_WIDTH_Y-1] = y[`MUL_WIDTH_Y-1];
	end

	// stage register, data only moves with a valid pair
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ppRows  <= '0;
			ppValid <= 1'b0;
		end else begin
			ppValid <= inValid; // gaps pass through unchanged
			if (inValid) begin
				ppRows <= ppNext;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/mulPipe_assert.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

module mulPipeAssert (
	input logic                 clk,
	input logic                 rstN,
	input logic                 inValid,
	input logic                 outValid,
	input mulPipePkg::product_t product
);

	logic [3:0] ticks; // edges since reset release, stops at the latency

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ticks <= '0;
		end else if (ticks < 4'(`MUL_LATENCY)) begin
			ticks <= ticks + 1'b1;
		end
	end

	// strobe comes out exactly latency edges after it went in
	strobeDelay: assert property (@(posedge clk) disable iff (!rstN)
		(ticks == 4'(`MUL_LATENCY)) |-> (outValid == $past(inValid, `MUL_LATENCY)))
		else $error("outValid does not follow inValid by the pipeline latency");

	// pipeline stays empty under reset
	resetQuiet: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid is high during reset");

	productKnown: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> !$isunknown(product))
		else $error("product holds unknown bits while outValid is high");

endmodule

bind mulPipe mulPipeAssert checks (
	.clk      (clk),
	.rstN     (rstN),
	.inValid  (inValid),
	.outValid (outValid),
	.product  (product)
);

`default_nettype wire

// ==== tests/mulPipe_tb.sv ====
`default_nettype none

`include "mulPipe_settings.svh"

module mulPipe_tb;

	localparam int clkPeriod   = 20;
	localparam int resetCycles = 16;
	localparam int randCount   = 300; // back-to-back pairs
	localparam int gapCount    = 200; // pairs with idle gaps
	localparam int signGroups  = 40;  // four pairs each
	localparam int midCount    = 20;  // pairs in flight when reset hits
	localparam int freshCount  = 30;  // pairs after the second reset
	// a gapped pair takes up to three cycles
	localparam int vectorCycles = 25 + randCount + 3 * gapCount + 4 * signGroups
		+ midCount + resetCycles + freshCount;
	localparam int timeLimit = (vectorCycles + resetCycles + 50) * clkPeriod;

	logic                  clk = 1'b0; // starts low without an edge at time zero
	logic                  rstN;
	logic                  inValid;
	mulPipePkg::operandX_t x;
	mulPipePkg::operandY_t y;
	mulPipePkg::product_t  product;
	logic                  outValid;

	mulPipePkg::product_t expQ[$]; // expected products in arrival order
	string                nameQ[$]; // test of each queued product
	string                testName;
	int                   valueErrors;
	int                   otherErrors;
	int                   checked;
	int unsigned          seedVal;
	int                   corners[5] = '{-128, -1, 0, 1, 127};

	mulPipe UUT (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.x        (x),
		.y        (y),
		.product  (product),
		.outValid (outValid)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// signed product wrapped to the product width
	function automatic mulPipePkg::product_t refProduct(input mulPipePkg::operandX_t a,
			input mulPipePkg::operandY_t b);
		longint sa;
		longint sb;
		sa = $signed(a); // sign extension
		sb = $signed(b);
		return mulPipePkg::product_t'(sa * sb);
	endfunction

	// one pair on the inputs for the next edge
	task automatic sendPair(input mulPipePkg::operandX_t a, input mulPipePkg::operandY_t b);
		@(posedge clk);
		inValid <= 1'b1;
		x       <= a;
		y       <= b;
		expQ.push_back(refProduct(a, b));
		nameQ.push_back(testName);
	endtask

	task automatic idleCycle();
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	// stop the stream and wait until every queued product came out
	task automatic drainPipe();
		idleCycle();
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// outputs settle long before the falling edge
	always @(negedge clk) begin : compare
		mulPipePkg::product_t expected;
		string                name;
		if (!rstN) begin
			assert (!outValid) else begin
				$display("outValid is high while reset is held, time %0t", $time);
				otherErrors++;
			end
		end else if (outValid) begin
			assert (expQ.size() != 0) else begin
				$display("unexpected product %0d with no pair in flight, time %0t",
					$signed(product), $time);
				otherErrors++;
			end
			if (expQ.size() != 0) begin
				expected = expQ.pop_front();
				name     = nameQ.pop_front();
				checked++;
				assert (product == expected) else begin
					$display("error %s expected %0d actual %0d", name, $signed(expected),
						$signed(product));
					valueErrors++;
				end
			end
		end
	end

	initial begin : watchdog
		#(timeLimit);
		$display("timeout, no end of test after %0d time units", timeLimit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : stimulus
		int gap;
		int sa;
		int sb;
		rstN        = 1'b0;
		inValid     = 1'b0;
		x           = '0;
		y           = '0;
		valueErrors = 0;
		otherErrors = 0;
		checked     = 0;
		seedVal     = $urandom(92134); // seeds the generator once
		testName    = "corners";
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		foreach (corners[i]) begin // all 25 pairings incl. -128 * -128
			foreach (corners[j]) begin
				sendPair(mulPipePkg::operandX_t'(corners[i]),
					mulPipePkg::operandY_t'(corners[j]));
			end
		end
		drainPipe();

		testName = "backToBack"; // three products in flight
		repeat (randCount) begin
			sendPair(mulPipePkg::operandX_t'($urandom), mulPipePkg::operandY_t'($urandom));
		end
		drainPipe();

		testName = "gapped";
		repeat (gapCount) begin
			gap = int'($urandom_range(2, 0)); // one idle cycle per pair on average
			repeat (gap) idleCycle();
			sendPair(mulPipePkg::operandX_t'($urandom), mulPipePkg::operandY_t'($urandom));
		end
		drainPipe();

		testName = "signSymmetry";
		repeat (signGroups) begin
			sa = int'($urandom_range(254, 0)) - 127; // -128 left out since it has no negation
			sb = int'($urandom_range(254, 0)) - 127;
			sendPair(mulPipePkg::operandX_t'(sa), mulPipePkg::operandY_t'(sb));
			sendPair(mulPipePkg::operandX_t'(-sa), mulPipePkg::operandY_t'(sb));
			sendPair(mulPipePkg::operandX_t'(sa), mulPipePkg::operandY_t'(-sb));
			sendPair(mulPipePkg::operandX_t'(-sa), mulPipePkg::operandY_t'(-sb));
		end
		drainPipe();

		testName = "resetMidStream";
		repeat (midCount) begin
			sendPair(mulPipePkg::operandX_t'($urandom), mulPipePkg::operandY_t'($urandom));
		end
		@(posedge clk);
		rstN    <= 1'b0; // products still in flight
		inValid <= 1'b0;
		expQ.delete();
		nameQ.delete();
		#1;
		assert (!outValid) else begin
			$display("outValid did not drop as soon as reset was applied");
			otherErrors++;
		end
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		repeat (freshCount) begin
			sendPair(mulPipePkg::operandX_t'($urandom), mulPipePkg::operandY_t'($urandom));
		end
		drainPipe();
		repeat (2 * `MUL_LATENCY) @(posedge clk); // room for a stray strobe

		$display("checked %0d products, %0d value errors, %0d other errors", checked,
			valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
